// File: all.f
mem_pkg.sv
mem_lane_if.sv
mem_lane_decode.sv
mem_bank_array.sv
mem_load_extend.sv
mem_access_top.sv
mem_access_assert.sv
tb_mem_access.sv
+incdir+.

// File: mem_access_assert.sv
`timescale 1ns/1ps

module mem_access_assert
(
    input logic             clk,
    input logic             reset,
    input logic             req_valid,
    input mem_pkg::mem_op_e req_op,
    input logic             rd_valid
);

    logic is_load;

    assign is_load = req_op inside {mem_pkg::OP_LB, mem_pkg::OP_LBU, mem_pkg::OP_LH,
                                    mem_pkg::OP_LHU, mem_pkg::OP_LW};

    // Decode, bank read and extend registers
    load_latency: assert property (@(posedge clk) disable iff (reset)
        req_valid && is_load |-> ##3 rd_valid)
        else $error("load result did not appear three cycles after the request");

    store_silent: assert property (@(posedge clk) disable iff (reset)
        req_valid && !is_load |-> ##3 !rd_valid)
        else $error("store produced a read result");

    reset_clear: assert property (@(posedge clk) reset |=> !rd_valid)
        else $error("read valid high after reset");

endmodule

bind mem_access_top mem_access_assert u_assert
(
    .clk       (clk),
    .reset     (reset),
    .req_valid (req_valid),
    .req_op    (req_op),
    .rd_valid  (rd_valid)
);

// File: mem_access_top.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module mem_access_top
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   req_valid,
    input  mem_pkg::mem_op_e       req_op,
    input  logic [`MEM_ADDR_W-1:0] req_addr,
    input  logic [`MEM_DATA_W-1:0] req_wdata,
    output logic                   rd_valid,
    output logic [`MEM_DATA_W-1:0] rd_data
);

    ////////////////////
    // Stage links
    ////////////////////

    mem_lane_req_if lane_req ();
    mem_lane_rsp_if lane_rsp ();

    // Stage 1 decodes lanes and aligns store data
    mem_lane_decode u_decode
    (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req_op    (req_op),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .lane_req  (lane_req.src)
    );

    // Stage 2 writes banks and registers the read
    mem_bank_array u_banks
    (
        .clk      (clk),
        .reset    (reset),
        .lane_req (lane_req.dst),
        .lane_rsp (lane_rsp.src)
    );

    // Stage 3 reorders and extends
    mem_load_extend u_extend
    (
        .clk      (clk),
        .reset    (reset),
        .lane_rsp (lane_rsp.dst),
        .rd_valid (rd_valid),
        .rd_data  (rd_data)
    );

endmodule

// File: mem_bank_array.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module mem_bank_array
(
    input  logic        clk,
    input  logic        reset,
    mem_lane_req_if.dst lane_req,
    mem_lane_rsp_if.src lane_rsp
);

    localparam int ROW_W = `MEM_ADDR_W - 2;
    localparam int ROWS  = 1 << ROW_W;

    logic wr_go;
    logic rd_go;

    assign wr_go = lane_req.valid && lane_req.is_store;
    assign rd_go = lane_req.valid && !lane_req.is_store;

    ////////////////////
    // Byte banks
    ////////////////////

    genvar b;
    generate
        for (b = 0; b < `MEM_LANES; b++)
        begin : g_bank
            logic [7:0] bank_mem [0:ROWS-1];
            logic [7:0] rd_byte;

            // Only the lanes covered by the store
            always_ff @(posedge clk)
            begin
                if (wr_go && lane_req.lane_en[b])
                    bank_mem[lane_req.lane_row[b]] <= lane_req.lane_wdata[b];
            end

            always_ff @(posedge clk)
            begin
                if (rd_go)
                    rd_byte <= bank_mem[lane_req.lane_row[b]];
            end

            assign lane_rsp.lane_rdata[b] = rd_byte;
        end
    endgenerate

    // Loads only; stores end here
    always_ff @(posedge clk)
    begin
        if (reset)
            lane_rsp.valid <= 1'b0;
        else
            lane_rsp.valid <= rd_go;
    end

    always_ff @(posedge clk)
    begin
        if (rd_go)
        begin
            lane_rsp.rot       <= lane_req.rot;
            lane_rsp.width     <= lane_req.width;
            lane_rsp.is_signed <= lane_req.is_signed;
        end
    end

endmodule

// File: mem_lane_decode.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module mem_lane_decode
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   req_valid,
    input  mem_pkg::mem_op_e       req_op,
    input  logic [`MEM_ADDR_W-1:0] req_addr,
    input  logic [`MEM_DATA_W-1:0] req_wdata,
    mem_lane_req_if.src            lane_req
);

    localparam int ROW_W = `MEM_ADDR_W - 2;

    mem_pkg::mem_width_e              width;
    logic                             is_store;
    logic                             is_signed;
    logic [2:0]                       size;
    logic [1:0]                       rot;
    logic [ROW_W-1:0]                 row;
    logic [ROW_W-1:0]                 row_next;
    logic [`MEM_LANES-1:0][1:0]       lane_ofs;
    logic [`MEM_LANES-1:0]            lane_en;
    logic [`MEM_LANES-1:0][ROW_W-1:0] lane_row;
    logic [`MEM_LANES-1:0][7:0]       lane_wdata;

    ////////////////////
    // Opcode decode
    ////////////////////

    always_comb
    begin
        width     = mem_pkg::W_WORD;
        is_store  = 1'b0;
        is_signed = 1'b0;
        case (req_op)
            mem_pkg::OP_LB:
            begin
                width     = mem_pkg::W_BYTE;
                is_signed = 1'b1;
            end
            mem_pkg::OP_LBU: width = mem_pkg::W_BYTE;
            mem_pkg::OP_LH:
            begin
                width     = mem_pkg::W_HALF;
                is_signed = 1'b1;
            end
            mem_pkg::OP_LHU: width = mem_pkg::W_HALF;
            mem_pkg::OP_SB:
            begin
                width    = mem_pkg::W_BYTE;
                is_store = 1'b1;
            end
            mem_pkg::OP_SH:
            begin
                width    = mem_pkg::W_HALF;
                is_store = 1'b1;
            end
            mem_pkg::OP_SW:  is_store = 1'b1;
            default:         width = mem_pkg::W_WORD;
        endcase
        case (width)
            mem_pkg::W_BYTE: size = 3'd1;
            mem_pkg::W_HALF: size = 3'd2;
            default:         size = 3'd4;
        endcase
    end

    ////////////////////
    // Lane mapping
    ////////////////////

    assign rot      = req_addr[1:0];
    assign row      = req_addr[`MEM_ADDR_W-1:2];
    // Wraps from the last row back to row 0
    assign row_next = row + 1'b1;

    always_comb
    begin
        for (int b = 0; b < `MEM_LANES; b++)
        begin
            // Position of this bank within the access
            lane_ofs[b]   = 2'(b) - rot;
            lane_en[b]    = {1'b0, lane_ofs[b]} < size;
            lane_row[b]   = (2'(b) >= rot) ? row : row_next;
            lane_wdata[b] = req_wdata[8*lane_ofs[b] +: 8];
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            lane_req.valid <= 1'b0;
        else
            lane_req.valid <= req_valid;
    end

    always_ff @(posedge clk)
    begin
        if (req_valid)
        begin
            lane_req.is_store   <= is_store;
            lane_req.lane_row   <= lane_row;
            lane_req.lane_en    <= lane_en;
            lane_req.lane_wdata <= lane_wdata;
            lane_req.rot        <= rot;
            lane_req.width      <= width;
            lane_req.is_signed  <= is_signed;
        end
    end

endmodule

// File: mem_lane_if.sv
`timescale 1ns/1ps
`include "mem_params.svh"

////////////////////
// Decode to banks
////////////////////

interface mem_lane_req_if;

    logic                                   valid;
    logic                                   is_store;
    // One row index per bank
    logic [`MEM_LANES-1:0][`MEM_ADDR_W-3:0] lane_row;
    logic [`MEM_LANES-1:0]                  lane_en;
    // Store bytes already in bank order
    logic [`MEM_LANES-1:0][7:0]             lane_wdata;
    logic [1:0]                             rot;
    mem_pkg::mem_width_e                    width;
    logic                                   is_signed;

    modport src (output valid, is_store, lane_row, lane_en, lane_wdata,
                 output rot, width, is_signed);
    modport dst (input valid, is_store, lane_row, lane_en, lane_wdata,
                 input rot, width, is_signed);

endinterface

////////////////////
// Banks to extend
////////////////////

interface mem_lane_rsp_if;

    logic                       valid;
    // Read bytes still in bank order
    logic [`MEM_LANES-1:0][7:0] lane_rdata;
    logic [1:0]                 rot;
    mem_pkg::mem_width_e        width;
    logic                       is_signed;

    modport src (output valid, lane_rdata, rot, width, is_signed);
    modport dst (input valid, lane_rdata, rot, width, is_signed);

endinterface

// File: mem_load_extend.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module mem_load_extend
(
    input  logic                   clk,
    input  logic                   reset,
    mem_lane_rsp_if.dst            lane_rsp,
    output logic                   rd_valid,
    output logic [`MEM_DATA_W-1:0] rd_data
);

    logic [`MEM_LANES-1:0][7:0] ordered;
    logic                       byte_fill;
    logic                       half_fill;
    logic [`MEM_DATA_W-1:0]     ext_data;

    ////////////////////
    // Undo rotation
    ////////////////////

    // Access byte i sits in bank (i + rot) mod 4
    always_comb
    begin
        for (int i = 0; i < `MEM_LANES; i++)
            ordered[i] = lane_rsp.lane_rdata[2'(i) + lane_rsp.rot];
    end

    ////////////////////
    // Extension
    ////////////////////

    assign byte_fill = lane_rsp.is_signed && ordered[0][7];
    assign half_fill = lane_rsp.is_signed && ordered[1][7];

    always_comb
    begin
        case (lane_rsp.width)
            mem_pkg::W_BYTE: ext_data = {{(`MEM_DATA_W-8){byte_fill}}, ordered[0]};
            mem_pkg::W_HALF: ext_data = {{(`MEM_DATA_W-16){half_fill}}, ordered[1], ordered[0]};
            default:         ext_data = ordered;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            rd_valid <= 1'b0;
        else
            rd_valid <= lane_rsp.valid;
    end

    always_ff @(posedge clk)
    begin
        if (lane_rsp.valid)
            rd_data <= ext_data;
    end

endmodule

// File: mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

////////////////////
// Memory geometry
////////////////////

// Byte address width for 1 KiB of data memory
`define MEM_ADDR_W 10

// Data bus width
`define MEM_DATA_W 32

// One byte-wide bank per data byte
`define MEM_LANES 4

`endif

// File: mem_pkg.sv
package mem_pkg;

    ////////////////////
    // Access opcodes
    ////////////////////

    typedef enum logic [3:0]
    {
        OP_LB  = 4'd0,
        OP_LBU = 4'd1,
        OP_LH  = 4'd2,
        OP_LHU = 4'd3,
        OP_LW  = 4'd4,
        OP_SB  = 4'd5,
        OP_SH  = 4'd6,
        OP_SW  = 4'd7
    } mem_op_e;

    // Bytes touched by one access
    typedef enum logic [1:0]
    {
        W_BYTE = 2'd0,
        W_HALF = 2'd1,
        W_WORD = 2'd2
    } mem_width_e;

endpackage

// File: tb_mem_access.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module tb_mem_access;

    localparam int PERIOD    = 100;
    // Fill, aligned, lanes, unaligned, random and idle requests
    localparam int REQ_TOTAL = 256 + 16 + 8 + 40 + 200 + 8;
    localparam int MARGIN    = 200;

    logic                   clk;
    logic                   reset;
    logic                   req_valid;
    mem_pkg::mem_op_e       req_op;
    logic [`MEM_ADDR_W-1:0] req_addr;
    logic [`MEM_DATA_W-1:0] req_wdata;
    logic                   rd_valid;
    logic [`MEM_DATA_W-1:0] rd_data;

    logic [7:0]             ref_mem [0:(1 << `MEM_ADDR_W)-1];
    logic [`MEM_DATA_W-1:0] exp_q [$];
    int                     due_q [$];
    int                     cycle_cnt;
    int                     errors;
    logic [31:0]            rng_state;

    mem_access_top u_dut
    (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req_op    (req_op),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data)
    );

    always #(PERIOD / 2) clk = ~clk;

    always @(posedge clk)
        cycle_cnt <= cycle_cnt + 1;

    ////////////////////
    // Reference model
    ////////////////////

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic int access_size(input mem_pkg::mem_op_e op);
        if (op inside {mem_pkg::OP_LB, mem_pkg::OP_LBU, mem_pkg::OP_SB})
            return 1;
        if (op inside {mem_pkg::OP_LH, mem_pkg::OP_LHU, mem_pkg::OP_SH})
            return 2;
        return 4;
    endfunction

    function automatic logic [31:0] expected_load(input mem_pkg::mem_op_e op,
                                                  input logic [9:0] addr);
        int          size;
        logic [31:0] val;
        size = access_size(op);
        val  = '0;
        for (int i = 0; i < size; i++)
            val[8*i +: 8] = ref_mem[10'(addr + i)];
        // Sign taken from the top loaded bit
        if ((op == mem_pkg::OP_LB || op == mem_pkg::OP_LH) && val[8*size-1])
            for (int i = size; i < 4; i++)
                val[8*i +: 8] = 8'hff;
        return val;
    endfunction

    function automatic logic [7:0] fill_byte(input logic [9:0] a);
        return a[7:0] ^ {4{a[9:8]}};
    endfunction

    task automatic fail_stop();
        errors++;
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    // Drive one request and update the model in issue order
    task automatic issue(input mem_pkg::mem_op_e op, input logic [9:0] addr,
                         input logic [31:0] wdata);
        req_valid = 1'b1;
        req_op    = op;
        req_addr  = addr;
        req_wdata = wdata;
        if (op inside {mem_pkg::OP_SB, mem_pkg::OP_SH, mem_pkg::OP_SW})
        begin
            for (int i = 0; i < access_size(op); i++)
                ref_mem[10'(addr + i)] = wdata[8*i +: 8];
        end
        else
        begin
            exp_q.push_back(expected_load(op, addr));
            due_q.push_back(cycle_cnt + 3);
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic drain();
        do
        begin
            @(posedge clk);
            #1;
        end
        while (due_q.size() != 0);
    endtask

    ////////////////////
    // Result monitor
    ////////////////////

    always @(negedge clk)
    begin
        if (!reset)
        begin
            if (due_q.size() > 0 && due_q[0] == cycle_cnt)
            begin
                assert (rd_valid === 1'b1)
                else
                begin
                    $display("ERROR t=%0t rd_valid got %b exp 1", $time, rd_valid);
                    fail_stop();
                end
                assert (rd_data === exp_q[0])
                else
                begin
                    $display("ERROR t=%0t rd_data got %h exp %h", $time, rd_data, exp_q[0]);
                    fail_stop();
                end
                void'(exp_q.pop_front());
                void'(due_q.pop_front());
            end
            else
            begin
                assert (rd_valid === 1'b0)
                else
                begin
                    $display("ERROR t=%0t rd_valid got %b exp 0", $time, rd_valid);
                    fail_stop();
                end
            end
        end
    end

    ////////////////////
    // Directed tests
    ////////////////////

    task automatic fill_memory();
        logic [9:0] a;
        for (int w = 0; w < 256; w++)
        begin
            a = 10'(4 * w);
            issue(mem_pkg::OP_SW, a, {fill_byte(a + 3), fill_byte(a + 2),
                                      fill_byte(a + 1), fill_byte(a)});
        end
    endtask

    task automatic word_aligned_test();
        logic [9:0]  addr [0:7];
        logic [31:0] r;
        for (int k = 0; k < 8; k++)
        begin
            r       = next_rand();
            addr[k] = {r[9:2], 2'b00};
            issue(mem_pkg::OP_SW, addr[k], next_rand());
        end
        for (int k = 0; k < 8; k++)
            issue(mem_pkg::OP_LW, addr[k], '0);
        drain();
    endtask

    task automatic byte_lane_test();
        logic [7:0] lane_byte [0:3];
        lane_byte = '{8'h81, 8'h22, 8'hc3, 8'h44};
        for (int k = 0; k < 4; k++)
            issue(mem_pkg::OP_SB, 10'(10'h100 + k), {24'hdead5a, lane_byte[k]});
        issue(mem_pkg::OP_LW, 10'h100, '0);
        issue(mem_pkg::OP_LB, 10'h100, '0);
        issue(mem_pkg::OP_LBU, 10'h100, '0);
        issue(mem_pkg::OP_LB, 10'h101, '0);
        drain();
    endtask

    // Row crossings and the wrap from the last byte to byte 0
    task automatic unaligned_test();
        logic [9:0]  list [0:7];
        logic [31:0] r;
        list = '{10'd1, 10'd2, 10'd3, 10'd6, 10'd255, 10'd1021, 10'd1022, 10'd1023};
        for (int k = 0; k < 8; k++)
        begin
            r     = next_rand();
            r[15] = k[0];
            issue(mem_pkg::OP_SH, list[k], r);
            issue(mem_pkg::OP_LH, list[k], '0);
            issue(mem_pkg::OP_LHU, list[k], '0);
            issue(mem_pkg::OP_SW, list[k], next_rand());
            issue(mem_pkg::OP_LW, list[k], '0);
        end
        drain();
    endtask

    task automatic random_test();
        logic [31:0] r;
        for (int n = 0; n < 100; n++)
        begin
            r = next_rand();
            issue(mem_pkg::mem_op_e'(4'(5 + r[31:16] % 3)), r[9:0], next_rand());
            issue(mem_pkg::mem_op_e'(4'(r[15:10] % 5)), r[9:0], '0);
        end
        drain();
    endtask

    task automatic idle_test();
        reset = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        for (int k = 0; k < 8; k++)
            issue(mem_pkg::OP_SW, 10'(next_rand()), next_rand());
        repeat (5) @(posedge clk);
        #1;
    endtask

    initial
    begin
        #((REQ_TOTAL + MARGIN) * PERIOD);
        $display("Watchdog expired before the tests finished");
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
    end

    initial
    begin
        clk       = 1'b0;
        reset     = 1'b1;
        req_valid = 1'b0;
        req_op    = mem_pkg::OP_LW;
        req_addr  = '0;
        req_wdata = '0;
        cycle_cnt = 0;
        errors    = 0;
        rng_state = 32'hce4d;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        fill_memory();
        word_aligned_test();
        byte_lane_test();
        unaligned_test();
        random_test();
        idle_test();
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
